// ==== Makefile ====
# Verilator flow for the DMC tester

TOP := tb_dmc_tester

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f sim.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f sim.f --top-module $(TOP) -o sim_tb
	./obj_dir/sim_tb | tee sim.log
	grep -q "\*\*\* TEST PASSED \*\*\*" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== hw/dmc_cmd_fifo.sv ====
/*
 * DMC command FIFO
 * Small circular buffer between the replay engine and the
 * memory target, ready when not full, valid when not empty
 */

`timescale 1ns/1ns

module dmc_cmd_fifo (
	input  logic                     clk_i,
	input  logic                     rst_n_i,

	input  logic                     push_valid_i,
	input  dmc_tester_pkg::mem_cmd_s push_cmd_i,
	output logic                     push_ready_o,

	output logic                     pop_valid_o,
	output dmc_tester_pkg::mem_cmd_s pop_cmd_o,
	input  logic                     pop_ready_i
);

	dmc_tester_pkg::mem_cmd_s mem [dmc_tester_pkg::fifo_depth_lp];

	logic [dmc_tester_pkg::fifo_ptr_width_lp-1:0] wr_ptr_r;
	logic [dmc_tester_pkg::fifo_ptr_width_lp-1:0] rd_ptr_r;
	logic [dmc_tester_pkg::fifo_cnt_width_lp-1:0] count_r;

	logic push_fire;
	logic pop_fire;

	assign push_ready_o = (count_r
		!= dmc_tester_pkg::fifo_cnt_width_lp'(dmc_tester_pkg::fifo_depth_lp));
	assign pop_valid_o  = (count_r != '0);
	assign pop_cmd_o    = mem[rd_ptr_r];

	assign push_fire = push_valid_i && push_ready_o;
	assign pop_fire  = pop_valid_o && pop_ready_i;

	// Storage
	always_ff @(posedge clk_i) begin
		if (push_fire) begin
			mem[wr_ptr_r] <= push_cmd_i;
		end
	end

	////////////////////////////////////////
	// Pointers and occupancy
	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			wr_ptr_r <= '0;
			rd_ptr_r <= '0;
			count_r  <= '0;
		end else begin
			if (push_fire) wr_ptr_r <= wr_ptr_r + 1'b1;
			if (pop_fire)  rd_ptr_r <= rd_ptr_r + 1'b1;
			case ({push_fire, pop_fire})
				2'b10:   count_r <= count_r + 1'b1;
				2'b01:   count_r <= count_r - 1'b1;
				default: count_r <= count_r;
			endcase
		end
	end

	// Pointers meet only when empty or full
	a_no_push_full: assert property (
		@(posedge clk_i) disable iff (!rst_n_i)
		push_fire |-> ((wr_ptr_r != rd_ptr_r) || (count_r == '0))
	) else $error("push accepted while full");

	a_no_pop_empty: assert property (
		@(posedge clk_i) disable iff (!rst_n_i)
		pop_fire |-> ((wr_ptr_r != rd_ptr_r)
			|| (count_r == dmc_tester_pkg::fifo_cnt_width_lp'(dmc_tester_pkg::fifo_depth_lp)))
	) else $error("pop taken while empty");

endmodule

// ==== hw/dmc_mem_target.sv ====
/*
 * DMC memory target
 * Word-addressed stand-in for the DRAM controller. Executes
 * writes at once and returns reads through one held register
 */

`timescale 1ns/1ns

module dmc_mem_target (
	input  logic                     clk_i,
	input  logic                     rst_n_i,
	input  logic                     stall_i,
	input  logic                     mem_fault_i,

	input  logic                     cmd_valid_i,
	input  dmc_tester_pkg::mem_cmd_s cmd_i,
	output logic                     cmd_ready_o,

	output logic                     rsp_valid_o,
	output dmc_tester_pkg::mem_rsp_s rsp_o,
	input  logic                     rsp_ready_i
);

	logic [dmc_tester_pkg::data_width_lp-1:0] mem [dmc_tester_pkg::mem_words_lp];

	logic [dmc_tester_pkg::mem_addr_width_lp-1:0] word_addr;
	logic [dmc_tester_pkg::data_width_lp-1:0]     rd_word;
	dmc_tester_pkg::mem_rsp_s                     rsp_r;
	logic                                         rsp_valid_r;
	logic                                         cmd_fire;

	// Only the low address bits select a word
	assign word_addr = cmd_i.addr[dmc_tester_pkg::mem_addr_width_lp-1:0];

	// Fault injection flips bit 0 of read data
	assign rd_word = mem[word_addr]
		^ {{(dmc_tester_pkg::data_width_lp-1){1'b0}}, mem_fault_i};

	// One response in flight at most
	assign cmd_ready_o = !stall_i && !rsp_valid_r;
	assign cmd_fire    = cmd_valid_i && cmd_ready_o;

	assign rsp_valid_o = rsp_valid_r;
	assign rsp_o       = rsp_r;

	////////////////////////////////////////
	// Array and response data
	always_ff @(posedge clk_i) begin
		if (cmd_fire && cmd_i.we) begin
			mem[word_addr] <= cmd_i.data;
		end
		if (cmd_fire && !cmd_i.we) begin
			rsp_r.data <= rd_word;
		end
	end

	// Response valid, cleared when taken
	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			rsp_valid_r <= 1'b0;
		end else if (cmd_fire && !cmd_i.we) begin
			rsp_valid_r <= 1'b1;
		end else if (rsp_valid_r && rsp_ready_i) begin
			rsp_valid_r <= 1'b0;
		end
	end

	a_rsp_stable: assert property (
		@(posedge clk_i) disable iff (!rst_n_i)
		(rsp_valid_o && !rsp_ready_i) |=> (rsp_valid_o && $stable(rsp_o))
	) else $error("response changed before it was taken");

endmodule

// ==== hw/dmc_tester_pkg.sv ====
/*
 * DMC tester package
 * Shared widths, trace opcodes, the trace-entry union and the
 * command and response records of the memory path
 */

package dmc_tester_pkg;

	////////////////////////////////////////
	// Widths and depths
	localparam int data_width_lp     = 32;
	localparam int addr_width_lp     = 8;
	localparam int mem_words_lp      = 16;
	localparam int mem_addr_width_lp = $clog2(mem_words_lp);
	localparam int rom_addr_width_lp = 6;
	localparam int trace_len_lp      = 49;
	localparam int fifo_depth_lp     = 4;
	localparam int fifo_ptr_width_lp = $clog2(fifo_depth_lp);
	localparam int fifo_cnt_width_lp = $clog2(fifo_depth_lp + 1);
	localparam int mismatch_width_lp = 8;

	// Trace layout: writes first, then read/recv pairs, then done
	localparam logic [rom_addr_width_lp-1:0] trace_rd_base_lp  = rom_addr_width_lp'(mem_words_lp);
	localparam logic [rom_addr_width_lp-1:0] trace_done_idx_lp = rom_addr_width_lp'(trace_len_lp - 1);

	// Data pattern f(k) = k * mult ^ xor
	localparam logic [data_width_lp-1:0] pat_mult_lp = 32'h0101_0101;
	localparam logic [data_width_lp-1:0] pat_xor_lp  = 32'hA5A5_0000;

	////////////////////////////////////////
	// Trace entry
	typedef enum logic [2:0] {
		op_write = 3'd0,
		op_read  = 3'd1,
		op_recv  = 3'd2,
		op_done  = 3'd3
	} trace_op_e;

	typedef struct packed {
		trace_op_e                opcode;
		logic [addr_width_lp-1:0] addr;
		logic [data_width_lp-1:0] data;
	} trace_send_s;

	typedef struct packed {
		trace_op_e                opcode;
		logic [7:0]               filler;
		logic [data_width_lp-1:0] exp_data;
	} trace_recv_s;

	// One ROM word, command view or expectation view
	typedef union packed {
		trace_send_s send;
		trace_recv_s recv;
	} trace_entry_u;

	////////////////////////////////////////
	// Memory path records
	typedef struct packed {
		logic                     we;
		logic [addr_width_lp-1:0] addr;
		logic [data_width_lp-1:0] data;
	} mem_cmd_s;

	typedef struct packed {
		logic [data_width_lp-1:0] data;
	} mem_rsp_s;

endpackage

// ==== hw/dmc_tester_top.sv ====
/*
 * DMC tester top
 * Replay engine and ROM feeding the memory target through
 * the command FIFO, all on one clock
 */

`timescale 1ns/1ns

module dmc_tester_top (
	input  logic                                         clk_i,
	input  logic                                         rst_n_i,
	input  logic                                         en_i,
	input  logic                                         stall_i,
	input  logic                                         mem_fault_i,
	output logic                                         done_o,
	output logic                                         error_o,
	output logic [dmc_tester_pkg::mismatch_width_lp-1:0] mismatch_count_o,
	output logic                                         rsp_valid_o,
	output logic [dmc_tester_pkg::data_width_lp-1:0]     rsp_data_o
);

	logic [dmc_tester_pkg::rom_addr_width_lp-1:0] rom_addr;
	dmc_tester_pkg::trace_entry_u                 rom_entry;

	// Replay to FIFO
	logic                     cmd_valid;
	dmc_tester_pkg::mem_cmd_s cmd;
	logic                     cmd_ready;

	// FIFO to memory target
	logic                     q_valid;
	dmc_tester_pkg::mem_cmd_s q_cmd;
	logic                     q_ready;

	// Memory target back to replay
	logic                     rsp_valid;
	dmc_tester_pkg::mem_rsp_s rsp;
	logic                     rsp_ready;

	// Mirror of the response transfer
	assign rsp_valid_o = rsp_valid && rsp_ready;
	assign rsp_data_o  = rsp.data;

	dmc_trace_rom trace_rom (
		.rom_addr_i (rom_addr),
		.entry_o    (rom_entry)
	);

	dmc_trace_replay trace_replay (
		.clk_i            (clk_i),
		.rst_n_i          (rst_n_i),
		.en_i             (en_i),
		.rom_addr_o       (rom_addr),
		.rom_entry_i      (rom_entry),
		.cmd_valid_o      (cmd_valid),
		.cmd_o            (cmd),
		.cmd_ready_i      (cmd_ready),
		.rsp_valid_i      (rsp_valid),
		.rsp_i            (rsp),
		.rsp_ready_o      (rsp_ready),
		.done_o           (done_o),
		.error_o          (error_o),
		.mismatch_count_o (mismatch_count_o)
	);

	dmc_cmd_fifo cmd_fifo (
		.clk_i        (clk_i),
		.rst_n_i      (rst_n_i),
		.push_valid_i (cmd_valid),
		.push_cmd_i   (cmd),
		.push_ready_o (cmd_ready),
		.pop_valid_o  (q_valid),
		.pop_cmd_o    (q_cmd),
		.pop_ready_i  (q_ready)
	);

	dmc_mem_target mem_target (
		.clk_i       (clk_i),
		.rst_n_i     (rst_n_i),
		.stall_i     (stall_i),
		.mem_fault_i (mem_fault_i),
		.cmd_valid_i (q_valid),
		.cmd_i       (q_cmd),
		.cmd_ready_o (q_ready),
		.rsp_valid_o (rsp_valid),
		.rsp_o       (rsp),
		.rsp_ready_i (rsp_ready)
	);

endmodule

// ==== hw/dmc_trace_replay.sv ====
/*
 * DMC trace replay engine
 * Walks the trace ROM, issues write and read commands, checks
 * each read response and keeps a sticky error and mismatch count
 */

`timescale 1ns/1ns

module dmc_trace_replay (
	input  logic                                         clk_i,
	input  logic                                         rst_n_i,
	input  logic                                         en_i,

	output logic [dmc_tester_pkg::rom_addr_width_lp-1:0] rom_addr_o,
	input  dmc_tester_pkg::trace_entry_u                 rom_entry_i,

	output logic                                         cmd_valid_o,
	output dmc_tester_pkg::mem_cmd_s                     cmd_o,
	input  logic                                         cmd_ready_i,

	input  logic                                         rsp_valid_i,
	input  dmc_tester_pkg::mem_rsp_s                     rsp_i,
	output logic                                         rsp_ready_o,

	output logic                                         done_o,
	output logic                                         error_o,
	output logic [dmc_tester_pkg::mismatch_width_lp-1:0] mismatch_count_o
);

	logic [dmc_tester_pkg::rom_addr_width_lp-1:0] ptr_r;
	logic [dmc_tester_pkg::mismatch_width_lp-1:0] count_r;
	logic                                         error_r;

	dmc_tester_pkg::trace_op_e op;
	logic                      is_send;
	logic                      is_recv;
	logic                      cmd_fire;
	logic                      rsp_fire;
	logic                      mismatch;

	////////////////////////////////////////
	// Decode of the current entry
	assign rom_addr_o = ptr_r;
	assign op         = rom_entry_i.send.opcode;
	assign is_send    = (op == dmc_tester_pkg::op_write) || (op == dmc_tester_pkg::op_read);
	assign is_recv    = (op == dmc_tester_pkg::op_recv);

	// Command side, send view of the word
	assign cmd_valid_o = en_i && is_send;
	assign cmd_o.we    = (op == dmc_tester_pkg::op_write);
	assign cmd_o.addr  = rom_entry_i.send.addr;
	assign cmd_o.data  = rom_entry_i.send.data;

	// Response side, receive view of the word
	assign rsp_ready_o = en_i && is_recv;
	assign mismatch    = (rsp_i.data != rom_entry_i.recv.exp_data);

	assign cmd_fire = cmd_valid_o && cmd_ready_i;
	assign rsp_fire = rsp_valid_i && rsp_ready_o;

	// Pointer parks on the done entry
	assign done_o           = (op == dmc_tester_pkg::op_done);
	assign error_o          = error_r;
	assign mismatch_count_o = count_r;

	////////////////////////////////////////
	// Trace pointer and checker state
	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			ptr_r   <= '0;
			count_r <= '0;
			error_r <= 1'b0;
		end else begin
			if (cmd_fire || rsp_fire) begin
				ptr_r <= ptr_r + 1'b1;
			end
			if (rsp_fire && mismatch) begin
				count_r <= count_r + 1'b1;
				error_r <= 1'b1;
			end
		end
	end

	// Command held steady until the FIFO takes it
	a_cmd_stable: assert property (
		@(posedge clk_i) disable iff (!rst_n_i)
		(cmd_valid_o && !cmd_ready_i) |=> $stable(cmd_o)
	) else $error("command changed while waiting for ready");

	// Responses only drained on an expectation slot, the second of each read pair
	a_rsp_ready_recv: assert property (
		@(posedge clk_i) disable iff (!rst_n_i)
		rsp_ready_o |-> ((ptr_r >= dmc_tester_pkg::trace_rd_base_lp)
			&& (ptr_r < dmc_tester_pkg::trace_done_idx_lp)
			&& (ptr_r[0] != dmc_tester_pkg::trace_rd_base_lp[0]))
	) else $error("rsp_ready raised outside a recv entry");

endmodule

// ==== hw/dmc_trace_rom.sv ====
/*
 * DMC trace ROM
 * Combinational trace store, builds each write, read and
 * check entry directly from its index
 */

`timescale 1ns/1ns

module dmc_trace_rom (
	input  logic [dmc_tester_pkg::rom_addr_width_lp-1:0] rom_addr_i,
	output dmc_tester_pkg::trace_entry_u                 entry_o
);

	logic [dmc_tester_pkg::rom_addr_width_lp-1:0] rel;
	logic [dmc_tester_pkg::rom_addr_width_lp-1:0] pair;

	// f(k) for a word index
	function automatic logic [dmc_tester_pkg::data_width_lp-1:0] pattern(
		input logic [dmc_tester_pkg::rom_addr_width_lp-1:0] k
	);
		logic [dmc_tester_pkg::data_width_lp-1:0] kw;
		kw = {{(dmc_tester_pkg::data_width_lp-dmc_tester_pkg::rom_addr_width_lp){1'b0}}, k};
		return (kw * dmc_tester_pkg::pat_mult_lp) ^ dmc_tester_pkg::pat_xor_lp;
	endfunction

	// Position inside the read/recv section, two entries per word
	assign rel  = rom_addr_i - dmc_tester_pkg::trace_rd_base_lp;
	assign pair = rel >> 1;

	always_comb begin
		entry_o = '0;
		entry_o.send.opcode = dmc_tester_pkg::op_done;
		if (rom_addr_i < dmc_tester_pkg::trace_rd_base_lp) begin
			entry_o.send.opcode = dmc_tester_pkg::op_write;
			entry_o.send.addr   = {{(dmc_tester_pkg::addr_width_lp-dmc_tester_pkg::rom_addr_width_lp){1'b0}}, rom_addr_i};
			entry_o.send.data   = pattern(rom_addr_i);
		end else if (rom_addr_i < dmc_tester_pkg::trace_done_idx_lp) begin
			if (!rel[0]) begin
				entry_o.send.opcode = dmc_tester_pkg::op_read;
				entry_o.send.addr   = {{(dmc_tester_pkg::addr_width_lp-dmc_tester_pkg::rom_addr_width_lp){1'b0}}, pair};
			end else begin
				entry_o.recv.opcode   = dmc_tester_pkg::op_recv;
				entry_o.recv.exp_data = pattern(pair);
			end
		end
	end

endmodule

// ==== sim.f ====
hw/dmc_tester_pkg.sv
hw/dmc_trace_rom.sv
hw/dmc_trace_replay.sv
hw/dmc_cmd_fifo.sv
hw/dmc_mem_target.sv
hw/dmc_tester_top.sv
tb/tb_dmc_tester.sv

// ==== tb/tb_dmc_tester.sv ====
/*
 * DMC tester testbench
 * Replays the trace under clean, stalled, faulty and paused
 * conditions and checks every read response against f(k)
 */

`timescale 1ns/1ns

module tb_dmc_tester;

	// Five tests of about 49 entries each, plus stall slack and margin
	localparam int cycle_limit = 5000;
	localparam int resp_total  = 16;

	logic        clk_i = 1'b0;
	logic        rst_n_i = 1'b0;
	logic        en_i = 1'b0;
	logic        stall_i = 1'b0;
	logic        mem_fault_i = 1'b0;
	logic        done_o;
	logic        error_o;
	logic [7:0]  mismatch_count_o;
	logic        rsp_valid_o;
	logic [31:0] rsp_data_o;

	string       test_name = "none";
	bit          fault_mode = 1'b0;
	bit          stall_rand = 1'b0;
	int          rsp_idx = 0;
	int          test_errs = 0;
	int          tests_run = 0;
	int          tests_failed = 0;
	int          cycle_cnt = 0;
	int unsigned rnd;
	logic [31:0] exp_word;

	dmc_tester_top dut0 (
		.clk_i            (clk_i),
		.rst_n_i          (rst_n_i),
		.en_i             (en_i),
		.stall_i          (stall_i),
		.mem_fault_i      (mem_fault_i),
		.done_o           (done_o),
		.error_o          (error_o),
		.mismatch_count_o (mismatch_count_o),
		.rsp_valid_o      (rsp_valid_o),
		.rsp_data_o       (rsp_data_o)
	);

	always #2 clk_i = ~clk_i;

	// Expected read data, f(k) with optional bit 0 flip
	function automatic logic [31:0] exp_data(input int k, input bit fault);
		logic [31:0] v;
		v = (32'(k) * 32'h0101_0101) ^ 32'hA5A5_0000;
		if (fault) v[0] = ~v[0];
		return v;
	endfunction

	task automatic report_value(input string what, input logic [31:0] exp, input logic [31:0] act);
		$display("[FAIL] %s: %s expected %0h, actual %0h", test_name, what, exp, act);
		test_errs++;
	endtask

	////////////////////////////////////////
	// Response checker, one index per transfer
	always @(posedge clk_i) begin
		if (!rst_n_i) begin
			rsp_idx = 0;
		end else if (rsp_valid_o) begin
			exp_word = exp_data(rsp_idx, fault_mode);
			if (rsp_data_o !== exp_word) begin
				$display("[FAIL] %s: response %0d expected %h, actual %h",
					test_name, rsp_idx, exp_word, rsp_data_o);
				test_errs++;
			end
			rsp_idx++;
		end
	end

	// Random back-pressure, new value each cycle
	initial begin
		void'($urandom(21032));
		forever begin
			@(posedge clk_i);
			#1;
			rnd = $urandom();
			stall_i = stall_rand ? rnd[0] : 1'b0;
		end
	end

	always @(posedge clk_i) begin
		cycle_cnt++;
		if (cycle_cnt >= cycle_limit) begin
			$display("Timeout: %s did not finish within %0d cycles", test_name, cycle_limit);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	////////////////////////////////////////
	// Test sequencing
	task automatic apply_reset();
		@(posedge clk_i);
		#1;
		rst_n_i = 1'b0;
		en_i    = 1'b0;
		repeat (16) @(posedge clk_i);
		#1;
		rst_n_i = 1'b1;
	endtask

	task automatic check_idle();
		@(posedge clk_i);
		if (done_o !== 1'b0) report_value("done_o after reset", 32'd0, 32'(done_o));
		if (error_o !== 1'b0) report_value("error_o after reset", 32'd0, 32'(error_o));
		if (rsp_valid_o !== 1'b0) report_value("rsp_valid_o after reset", 32'd0, 32'(rsp_valid_o));
		if (mismatch_count_o !== 8'd0)
			report_value("mismatch count after reset", 32'd0, 32'(mismatch_count_o));
	endtask

	task automatic run_trace(input string name, input bit use_stall, input bit use_fault,
		input int pause_cycles);
		test_name   = name;
		test_errs   = 0;
		fault_mode  = use_fault;
		stall_rand  = 1'b0;
		apply_reset();
		mem_fault_i = use_fault;
		check_idle();
		if (pause_cycles > 0) begin
			repeat (pause_cycles) @(posedge clk_i);
			if (rsp_idx != 0) report_value("responses while paused", 32'd0, 32'(rsp_idx));
			if (done_o !== 1'b0) report_value("done_o while paused", 32'd0, 32'(done_o));
		end
		#1;
		stall_rand = use_stall;
		en_i       = 1'b1;
		while (done_o !== 1'b1) @(posedge clk_i);
		#1;
		stall_rand = 1'b0;
		if (rsp_idx != resp_total) report_value("response count", 32'(resp_total), 32'(rsp_idx));
		if (error_o !== use_fault) report_value("error_o", 32'(use_fault), 32'(error_o));
		if (use_fault && mismatch_count_o !== 8'd16)
			report_value("mismatch count", 32'd16, 32'(mismatch_count_o));
		if (!use_fault && mismatch_count_o !== 8'd0)
			report_value("mismatch count", 32'd0, 32'(mismatch_count_o));
		// Done must hold
		repeat (3) @(posedge clk_i);
		if (done_o !== 1'b1) report_value("done_o held", 32'd1, 32'(done_o));
		tests_run++;
		if (test_errs != 0) tests_failed++;
		$display("%-12s %s (%0d errors)", name, (test_errs == 0) ? "ok" : "FAILED", test_errs);
	endtask

	initial begin
		test_name = "reset_state";
		test_errs = 0;
		apply_reset();
		check_idle();
		tests_run++;
		if (test_errs != 0) tests_failed++;
		$display("%-12s %s (%0d errors)", test_name, (test_errs == 0) ? "ok" : "FAILED", test_errs);

		run_trace("clean_run", 1'b0, 1'b0, 0);
		run_trace("stall_run", 1'b1, 1'b0, 0);
		run_trace("fault_run", 1'b0, 1'b1, 0);
		run_trace("pause_run", 1'b0, 1'b0, 100);

		$display("Tests run: %0d, passed: %0d, failed: %0d",
			tests_run, tests_run - tests_failed, tests_failed);
		if (tests_failed == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule
